/* fir_stimulus.dat */
# W addr data | S valid value count (repeated samples) | E n v1 .. vn (expected outputs)
# expected values follow the 18-bit wrap and >>>17 scaling rules
# impulse with the reset coefficients
S 1 65536 1
S 1 0 25
E 13 44 0 -49 -99 -147 -190 -224 -245 -252 -241 -210 -160 -89
E 13 -89 -160 -210 -241 -252 -245 -224 -190 -147 -99 -49 0 44
# dense full-scale stream, pair sums wrap once both taps are loaded
S 1 131071 14
E 14 87 87 -10 -207 -501 -881 -1328 -1818 -2322 -2803 -3223 -3542 -3720 -3542
# invalid cycles still shift the taps
S 0 131071 2
S 1 131071 1
E 1 -2322
# drain the tap line
S 0 0 26
# reload, address 14 must be ignored
W 0 1000
W 12 -2000
W 14 555
W 5 300
S 1 65536 1
S 1 0 25
E 13 500 0 -49 -99 -147 150 -224 -245 -252 -241 -210 -160 -1000
E 13 -1000 -160 -210 -241 -252 -245 -224 150 -147 -99 -49 0 500

/* verilog.f */
fir_pkg.sv
fir_coeff_regs.sv
fir_tap_line.sv
fir_preadd_mult.sv
fir_adder_tree.sv
fir_top.sv
tb_clock_gen.sv
tb_fir_checker.sv
tb_fir_top.sv

/* Makefile */
TOP = tb_fir_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -o sim_fir

run: build
	./obj_dir/sim_fir | tee sim.log
	grep -q "Test OK" sim.log

lint:
	verilator --lint-only -Wall fir_pkg.sv fir_coeff_regs.sv fir_tap_line.sv \
		fir_preadd_mult.sv fir_adder_tree.sv fir_top.sv --top-module fir_top

clean:
	rm -rf obj_dir sim.log

/* tb_fir_top.sv */
// *********************************************************************
// FIR testbench, stimulus from fir_stimulus.dat
// random 0 to 2 stall cycles go in before every sample
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_fir_top;

	localparam int CLK_PERIOD = 20;

	logic                               clk;
	logic                               reset;
	logic                               clk_ena;
	logic                               valid;
	fir_pkg::sample_t                   sample;
	logic                               coeff_wr;
	logic [fir_pkg::COEFF_ADDR_W-1:0]   coeff_addr;
	fir_pkg::sample_t                   coeff_data;
	logic                               out_valid;
	fir_pkg::sample_t                   out_sample;
	int                                 pending;
	int                                 mismatch;
	int                                 extra;
	int                                 file_errors = 0;

	// one entry per write or per driven sample
	byte  kind_q [$];
	int   a_q [$];
	int   b_q [$];
	logic load_done = 1'b0;

	tb_clock_gen u_clock (
		.o_clk   (clk),
		.o_reset (reset)
	);

	fir_top uut (
		.clk          (clk),
		.reset        (reset),
		.i_clk_ena    (clk_ena),
		.i_valid      (valid),
		.i_sample     (sample),
		.i_coeff_wr   (coeff_wr),
		.i_coeff_addr (coeff_addr),
		.i_coeff_data (coeff_data),
		.o_valid      (out_valid),
		.o_sample     (out_sample)
	);

	tb_fir_checker u_checker (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (clk_ena),
		.i_valid    (out_valid),
		.i_sample   (out_sample),
		.o_pending  (pending),
		.o_mismatch (mismatch),
		.o_extra    (extra)
	);

	// *****************************************************************
	// stimulus file
	// *****************************************************************
	task automatic read_records();
		int               fd;
		int               code;
		int               a;
		int               b;
		int               n;
		logic [63:0]      tok;
		logic [8*160-1:0] line;
		fd = $fopen("fir_stimulus.dat", "r");
		if (fd == 0) begin
			$display("cannot open fir_stimulus.dat");
			file_errors = file_errors + 1;
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1) break;
			if (tok == "W") begin
				code = $fscanf(fd, "%d %d", a, b);
				kind_q.push_back("W");
				a_q.push_back(a);
				b_q.push_back(b);
			end else if (tok == "S") begin
				code = $fscanf(fd, "%d %d %d", a, b, n);
				for (int k = 0; k < n; k++) begin
					kind_q.push_back("S");
					a_q.push_back(a);
					b_q.push_back(b);
				end
			end else if (tok == "E") begin
				code = $fscanf(fd, "%d", n);
				for (int k = 0; k < n; k++) begin
					code = $fscanf(fd, "%d", a);
				end
			end else begin
				code = $fgets(line, fd);
			end
		end
		$fclose(fd);
	endtask

	task automatic write_coeff(input int addr, input int data);
		clk_ena    = 1'b0;
		coeff_wr   = 1'b1;
		coeff_addr = fir_pkg::COEFF_ADDR_W'(addr);
		coeff_data = fir_pkg::sample_t'(data);
		@(posedge clk);
		#2 coeff_wr = 1'b0;
	endtask

	task automatic drive_sample(input int vld, input int value);
		int stalls;
		stalls = int'($urandom % 3);
		repeat (stalls) begin
			clk_ena = 1'b0;
			valid   = 1'b0;
			@(posedge clk);
			#2;
		end
		clk_ena = 1'b1;
		valid   = (vld != 0);
		sample  = fir_pkg::sample_t'(value);
		@(posedge clk);
		#2 clk_ena = 1'b0;
	endtask

	task automatic report_and_finish();
		$display("errors: %0d mismatched, %0d extra, %0d missing, %0d file open",
			mismatch, extra, pending, file_errors);
		if (mismatch == 0 && extra == 0 && pending == 0 && file_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	endtask

	// *****************************************************************
	// main sequence
	// *****************************************************************
	initial begin
		clk_ena    = 1'b0;
		valid      = 1'b0;
		sample     = '0;
		coeff_wr   = 1'b0;
		coeff_addr = '0;
		coeff_data = '0;
		void'($urandom(52132));
		read_records();
		load_done = 1'b1;
		@(negedge reset);
		@(posedge clk);
		#2;
		for (int r = 0; r < kind_q.size(); r++) begin
			if (kind_q[r] == "W") begin
				write_coeff(a_q[r], b_q[r]);
			end else begin
				drive_sample(a_q[r], b_q[r]);
			end
		end
		// flush with invalid zeros until every expected value is seen
		clk_ena = 1'b1;
		valid   = 1'b0;
		sample  = '0;
		while (pending > 0) begin
			@(posedge clk);
		end
		repeat (fir_pkg::FIR_LATENCY + 2) @(posedge clk);
		report_and_finish();
	end

	// watchdog sized from the record count
	initial begin
		wait (load_done);
		#((kind_q.size() * 4 + 100) * CLK_PERIOD);
		$display("timeout: run did not finish, %0d outputs still expected", pending);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb_fir_checker.sv */
// *********************************************************************
// output checker, expected values come from the E records in order
// an output counts as new only after an enabled clock edge
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_fir_checker (
	input  wire                clk,
	input  wire                reset,
	input  wire                i_clk_ena,
	input  wire                i_valid,
	input  fir_pkg::sample_t   i_sample,
	output int                 o_pending,
	output int                 o_mismatch,
	output int                 o_extra
);

	int   expected [$];
	int   pending = 0;
	int   mismatch = 0;
	int   extra = 0;
	int   seen = 0;
	logic ena_q = 1'b0;

	assign o_pending  = pending;
	assign o_mismatch = mismatch;
	assign o_extra    = extra;

	// collect the expected outputs, other records are skipped
	initial begin : load_expected
		int               fd;
		int               code;
		int               n;
		int               v;
		logic [63:0]      tok;
		logic [8*160-1:0] line;
		fd = $fopen("fir_stimulus.dat", "r");
		if (fd == 0) begin
			$display("checker cannot open fir_stimulus.dat");
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", tok);
				if (code != 1) break;
				if (tok == "E") begin
					code = $fscanf(fd, "%d", n);
					for (int k = 0; k < n; k++) begin
						code = $fscanf(fd, "%d", v);
						expected.push_back(v);
					end
				end else begin
					code = $fgets(line, fd);
				end
			end
			$fclose(fd);
		end
		pending = expected.size();
	end

	// *****************************************************************
	// compare
	// *****************************************************************
	always @(posedge clk) begin
		if (reset) begin
			if (i_valid) begin
				$display("output valid went high during reset at %0t", $time);
				extra = extra + 1;
			end
			ena_q = 1'b0;
		end else begin
			if (ena_q && i_valid) begin
				if (pending == 0) begin
					$display("extra output %0d at %0t, no expected value left",
						int'(i_sample), $time);
					extra = extra + 1;
				end else begin
					if (int'(i_sample) != expected[0]) begin
						$display("** Error @ %0t: output %0d is %0d, expected %0d",
							$time, seen, int'(i_sample), expected[0]);
						mismatch = mismatch + 1;
					end
					void'(expected.pop_front());
					pending = expected.size();
				end
				seen = seen + 1;
			end
			ena_q = i_clk_ena;
		end
	end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// *********************************************************************
// testbench clock and reset, 20 ns period
// reset is held for 16 rising edges and drops 2 ns after an edge
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic o_clk,
	output logic o_reset
);

	initial begin
		o_clk = 1'b0;
		forever #10 o_clk = ~o_clk;
	end

	initial begin
		o_reset = 1'b1;
		repeat (16) @(posedge o_clk);
		#2 o_reset = 1'b0;
	end

endmodule

`default_nettype wire

/* fir_top.sv */
// *********************************************************************
// 26-tap symmetric FIR, output FIR_LATENCY enabled edges after input
// i_clk_ena low freezes the datapath, coefficient writes still land
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none

module fir_top (
	input  wire                                clk,
	input  wire                                reset,
	input  wire                                i_clk_ena,
	input  wire                                i_valid,
	input  fir_pkg::sample_t                   i_sample,
	input  wire                                i_coeff_wr,
	input  wire [fir_pkg::COEFF_ADDR_W-1:0]    i_coeff_addr,
	input  fir_pkg::sample_t                   i_coeff_data,
	output logic                               o_valid,
	output fir_pkg::sample_t                   o_sample
);

	fir_pkg::sample_t   coeffs [fir_pkg::NUM_UNIQ];
	fir_pkg::sample_t   taps [fir_pkg::NUM_TAPS];
	fir_pkg::sample_t   products [fir_pkg::NUM_UNIQ];
	logic               tap_valid;
	logic               prod_valid;

	// *****************************************************************
	// coefficients
	// *****************************************************************
	fir_coeff_regs u_coeff_regs (
		.clk          (clk),
		.reset        (reset),
		.i_coeff_wr   (i_coeff_wr),
		.i_coeff_addr (i_coeff_addr),
		.i_coeff_data (i_coeff_data),
		.o_coeffs     (coeffs)
	);

	// *****************************************************************
	// datapath
	// *****************************************************************
	fir_tap_line u_tap_line (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_sample  (i_sample),
		.o_taps    (taps),
		.o_valid   (tap_valid)
	);

	fir_preadd_mult u_preadd_mult (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_taps     (taps),
		.i_coeffs   (coeffs),
		.i_valid    (tap_valid),
		.o_products (products),
		.o_valid    (prod_valid)
	);

	fir_adder_tree u_adder_tree (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_products (products),
		.i_valid    (prod_valid),
		.o_sum      (o_sample),
		.o_valid    (o_valid)
	);

endmodule

`default_nettype wire

/* fir_adder_tree.sv */
// *********************************************************************
// four-level registered sum of the 13 products
// every add wraps at 18 bits, odd entries pass through as a bye
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none

module fir_adder_tree (
	input  wire                clk,
	input  wire                reset,
	input  wire                i_clk_ena,
	input  fir_pkg::sample_t   i_products [fir_pkg::NUM_UNIQ],
	input  wire                i_valid,
	output fir_pkg::sample_t   o_sum,
	output logic               o_valid
);

	// 13 -> 7 -> 4 -> 2 -> 1
	fir_pkg::sample_t                   lvl1_q [7];
	fir_pkg::sample_t                   lvl2_q [4];
	fir_pkg::sample_t                   lvl3_q [2];
	logic [fir_pkg::TREE_LEVELS-1:0]    vld_q;

	// *****************************************************************
	// data levels
	// *****************************************************************
	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			// level 1, six pairs plus the bye of product 12
			for (int k = 0; k < fir_pkg::NUM_UNIQ / 2; k++) begin
				lvl1_q[k] <= i_products[2*k] + i_products[2*k+1];
			end
			lvl1_q[6] <= i_products[fir_pkg::NUM_UNIQ-1];

			// level 2, three pairs plus a bye
			for (int k = 0; k < 3; k++) begin
				lvl2_q[k] <= lvl1_q[2*k] + lvl1_q[2*k+1];
			end
			lvl2_q[3] <= lvl1_q[6];

			// level 3
			lvl3_q[0] <= lvl2_q[0] + lvl2_q[1];
			lvl3_q[1] <= lvl2_q[2] + lvl2_q[3];

			// final sum
			o_sum <= lvl3_q[0] + lvl3_q[1];
		end
	end

	// *****************************************************************
	// valid pipe, one bit per level
	// *****************************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			vld_q <= '0;
		end else if (i_clk_ena) begin
			vld_q <= {vld_q[fir_pkg::TREE_LEVELS-2:0], i_valid};
		end
	end

	assign o_valid = vld_q[fir_pkg::TREE_LEVELS-1];

endmodule

`default_nettype wire

/* fir_preadd_mult.sv */
// *********************************************************************
// symmetric pre-add then scaled multiply, two register stages
// pair sums wrap at 18 bits before the multiply
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none

module fir_preadd_mult (
	input  wire                clk,
	input  wire                reset,
	input  wire                i_clk_ena,
	input  fir_pkg::sample_t   i_taps [fir_pkg::NUM_TAPS],
	input  fir_pkg::sample_t   i_coeffs [fir_pkg::NUM_UNIQ],
	input  wire                i_valid,
	output fir_pkg::sample_t   o_products [fir_pkg::NUM_UNIQ],
	output logic               o_valid
);

	fir_pkg::sample_t                     pre_q [fir_pkg::NUM_UNIQ];
	logic signed [fir_pkg::PROD_W-1:0]    prod_full [fir_pkg::NUM_UNIQ];
	logic                                 pre_valid;

	// *****************************************************************
	// pre-add stage
	// *****************************************************************
	// tap k and tap 25-k share coefficient k
	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int k = 0; k < fir_pkg::NUM_UNIQ; k++) begin
				pre_q[k] <= i_taps[k] + i_taps[fir_pkg::NUM_TAPS-1-k];
			end
		end
	end

	// *****************************************************************
	// multiply stage
	// *****************************************************************
	// full signed product, both operands sign extended
	always_comb begin
		for (int k = 0; k < fir_pkg::NUM_UNIQ; k++) begin
			prod_full[k] = fir_pkg::PROD_W'(pre_q[k]) * fir_pkg::PROD_W'(i_coeffs[k]);
		end
	end

	// arithmetic shift, keep the low 18 bits
	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int k = 0; k < fir_pkg::NUM_UNIQ; k++) begin
				o_products[k] <= fir_pkg::sample_t'(prod_full[k] >>> fir_pkg::SCALE_SHIFT);
			end
		end
	end

	// valid follows the two data stages
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pre_valid <= 1'b0;
			o_valid   <= 1'b0;
		end else if (i_clk_ena) begin
			pre_valid <= i_valid;
			o_valid   <= pre_valid;
		end
	end

endmodule

`default_nettype wire

/* fir_tap_line.sv */
// *********************************************************************
// 26-deep sample delay line, shifts only on enabled edges
// invalid samples still shift in, the valid bit rides with tap 0
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none

module fir_tap_line (
	input  wire                clk,
	input  wire                reset,
	input  wire                i_clk_ena,
	input  wire                i_valid,
	input  fir_pkg::sample_t   i_sample,
	output fir_pkg::sample_t   o_taps [fir_pkg::NUM_TAPS],
	output logic               o_valid
);

	// *****************************************************************
	// sample shift register
	// *****************************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
				o_taps[k] <= '0;
			end
		end else if (i_clk_ena) begin
			o_taps[0] <= i_sample;
			// oldest sample falls off the end
			for (int k = 1; k < fir_pkg::NUM_TAPS; k++) begin
				o_taps[k] <= o_taps[k-1];
			end
		end
	end

	// valid for the newest sample in tap 0
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_valid <= 1'b0;
		end else if (i_clk_ena) begin
			o_valid <= i_valid;
		end
	end

endmodule

`default_nettype wire

/* fir_coeff_regs.sv */
// *********************************************************************
// coefficient bank, writes land on the edge after the strobe
// writes ignore i_clk_ena, addresses of 13 and above are dropped
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none

module fir_coeff_regs (
	input  wire                                clk,
	input  wire                                reset,
	input  wire                                i_coeff_wr,
	input  wire [fir_pkg::COEFF_ADDR_W-1:0]    i_coeff_addr,
	input  fir_pkg::sample_t                   i_coeff_data,
	output fir_pkg::sample_t                   o_coeffs [fir_pkg::NUM_UNIQ]
);

	logic addr_ok;

	// only the 13 unique coefficients exist
	assign addr_ok = int'(i_coeff_addr) < fir_pkg::NUM_UNIQ;

	// *****************************************************************
	// register bank
	// *****************************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < fir_pkg::NUM_UNIQ; k++) begin
				o_coeffs[k] <= fir_pkg::RESET_COEFFS[k];
			end
		end else if (i_coeff_wr && addr_ok) begin
			// one word per strobe
			o_coeffs[i_coeff_addr] <= i_coeff_data;
		end
	end

endmodule

`default_nettype wire

/* fir_pkg.sv */
// *********************************************************************
// shared constants for the 26-tap symmetric FIR
// all arithmetic is 18-bit signed and wraps, products are 36-bit
// *********************************************************************
`default_nettype none

package fir_pkg;

	// sample and coefficient width
	localparam int DATA_W = 18;
	// full multiplier result
	localparam int PROD_W = 36;
	// product normalization
	localparam int SCALE_SHIFT = 17;

	localparam int NUM_TAPS = 26;
	// symmetric filter, half the taps
	localparam int NUM_UNIQ = 13;
	localparam int COEFF_ADDR_W = 4;

	// 13 -> 7 -> 4 -> 2 -> 1
	localparam int TREE_LEVELS = 4;
	// tap line 1, pre-add 1, multiply 1, tree 4
	localparam int FIR_LATENCY = 7;

	typedef logic signed [DATA_W-1:0] sample_t;

	// low-pass set loaded at reset
	localparam sample_t RESET_COEFFS [NUM_UNIQ] = '{
		18'sd88, 18'sd0, -18'sd97, -18'sd197,
		-18'sd294, -18'sd380, -18'sd447, -18'sd490,
		-18'sd504, -18'sd481, -18'sd420, -18'sd319,
		-18'sd178
	};

endpackage

`default_nettype wire
